/* design/sst_settings.svh */
`ifndef SST_SETTINGS_SVH
`define SST_SETTINGS_SVH

// save-state address space seen by cpu and host
`define SS_AW 11

// sniffer covers ss_addr 0x000 to 0x1ff
`define SNIF_AW 9

// cpu side register pair
`define SST_ADDR_REG 16'h40f2
`define SST_DATA_REG 16'h40f3

// signature byte at 0x0cf
`define SS_MAGIC 8'h53

// disabled joypad key
`define KEY_OFF 8'hff

`endif

/* design/nes_bus_pkg.sv */
`default_nettype none

package nes_bus_pkg;

	// one cpu bus cycle, sampled on the rising edge of m2
	typedef struct packed
	{
		logic [15:0] cpu_addr;
		logic [7:0] cpu_dat;
		logic cpu_rw;
	} cpu_bus_t;

	// ppu register index, cpu_addr[2:0] within $2000-$3fff
	typedef enum logic [2:0]
	{
		PPU_CTRL = 3'd0,
		PPU_MASK = 3'd1,
		PPU_STAT = 3'd2,
		PPU_OADR = 3'd3,
		PPU_ODAT = 3'd4,
		PPU_SCRL = 3'd5,
		PPU_ADDR = 3'd6,
		PPU_DATA = 3'd7
	} ppu_reg_e;

	// low byte of the nmi vector
	localparam logic [15:0] NMI_VEC_LO = 16'hfffa;

	// joypad strobe write and joypad 1 read
	localparam logic [15:0] JOY_PORT = 16'h4016;

endpackage

`default_nettype wire

/* design/sst_pkg.sv */
`default_nettype none

`include "sst_settings.svh"

package sst_pkg;

	// user settings from the menu
	typedef struct packed
	{
		logic ss_on;
		logic ss_btn;
		logic fds_sw;
		logic [7:0] key_save;
		logic [7:0] key_load;
	} sys_cfg_t;

	// what caused the last request
	typedef struct packed
	{
		logic btn;
		logic load;
		logic save;
	} ss_src_t;

	// towards the external save-state memory
	typedef struct packed
	{
		logic act;
		logic we;
		logic [`SS_AW-1:0] addr;
	} ss_ctrl_t;

endpackage

`default_nettype wire

/* design/ram_dp.sv */
`default_nettype none

module ram_dp
#(
	parameter int ADDR_W = 6
)
(
	input logic m2,
	input logic we,
	input logic [ADDR_W-1:0] wr_addr,
	input logic [7:0] din,
	input logic [ADDR_W-1:0] rd_addr,
	output logic [7:0] dout
);

	logic [7:0] mem [2**ADDR_W];

	always_ff @(posedge m2)
	begin
		if (we)
		begin
			mem[wr_addr] <= din;
		end
	end

	// registered read, data follows the address by one cycle
	always_ff @(posedge m2)
	begin
		dout <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* design/joy_rdr.sv */
`default_nettype none

module joy_rdr
(
	input logic m2,
	input logic map_rst,
	input nes_bus_pkg::cpu_bus_t bus,
	output logic [7:0] joy
);

	logic port_hit;
	logic strobe;
	logic [8:0] shreg;

	assign port_hit = bus.cpu_addr == nes_bus_pkg::JOY_PORT;

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			strobe <= 1'b0;
			shreg <= 9'd0;
			joy <= 8'h00;
		end
		else
		begin
			if (port_hit && !bus.cpu_rw)
			begin
				strobe <= bus.cpu_dat[0];
			end

			// sentinel in bit 0, a full byte once it reaches bit 8
			if (strobe)
			begin
				shreg <= 9'd1;
			end
			else if (shreg[8])
			begin
				joy <= shreg[7:0];
			end
			else if (port_hit && bus.cpu_rw)
			begin
				// first button ends up in the msb
				shreg <= {shreg[7:0], bus.cpu_dat[0] | bus.cpu_dat[1]};
			end
		end
	end

endmodule

`default_nettype wire

/* design/sniffer.sv */
`default_nettype none

`include "sst_settings.svh"

module sniffer
(
	input logic m2,
	input nes_bus_pkg::cpu_bus_t bus,
	input logic sniff_off,
	input sst_pkg::ss_src_t ss_src,
	input logic [`SNIF_AW-1:0] rd_addr,
	output logic [7:0] dout
);

	nes_bus_pkg::ppu_reg_e ppu_idx;
	logic ppu_ce;
	logic apu_ce;
	logic ppu_rd;
	logic ppu_we;
	logic apu_we;
	logic pal_we;
	logic oam_we;

	logic [7:0] ppu_ctrl;
	logic [7:0] ppu_mask;
	logic [15:0] ppu_scrl;
	logic [13:0] vram_addr;
	logic wr_tog;
	logic [7:0] oam_addr;

	logic [5:0] mem_wa;
	logic [5:0] mem_wa_pm;
	logic [5:0] mem_ra_pm;
	logic mem_we;
	logic [7:0] mem_do;
	logic [7:0] oam_do;

	logic [7:0] regs_byte;
	logic [7:0] regs_q;
	logic sel_oam_q;
	logic sel_mem_q;

	assign ppu_idx = nes_bus_pkg::ppu_reg_e'(bus.cpu_addr[2:0]);

	// $2000-$3fff with mirrors, $4000-$401f
	assign ppu_ce = bus.cpu_addr[15:13] == 3'b001;
	assign apu_ce = bus.cpu_addr[15:5] == 11'h200;

	assign ppu_rd = ppu_ce && bus.cpu_rw;
	assign ppu_we = ppu_ce && !bus.cpu_rw && !sniff_off;
	assign apu_we = apu_ce && !bus.cpu_rw && !sniff_off;
	assign pal_we = ppu_we && ppu_idx == nes_bus_pkg::PPU_DATA && vram_addr[13:8] == 6'h3f;
	assign oam_we = ppu_we && ppu_idx == nes_bus_pkg::PPU_ODAT;

	always_ff @(posedge m2)
	begin
		if (ppu_rd && ppu_idx == nes_bus_pkg::PPU_STAT)
		begin
			wr_tog <= 1'b0;
		end

		if (ppu_we)
		begin
			case (ppu_idx)
				nes_bus_pkg::PPU_CTRL: ppu_ctrl <= bus.cpu_dat;
				nes_bus_pkg::PPU_MASK: ppu_mask <= bus.cpu_dat;
				nes_bus_pkg::PPU_OADR: oam_addr <= bus.cpu_dat;
				nes_bus_pkg::PPU_ODAT: oam_addr <= oam_addr + 8'd1;
				nes_bus_pkg::PPU_SCRL:
				begin
					if (wr_tog)
						ppu_scrl[7:0] <= bus.cpu_dat;
					else
						ppu_scrl[15:8] <= bus.cpu_dat;
					wr_tog <= !wr_tog;
				end
				// scroll and vram address share the toggle
				nes_bus_pkg::PPU_ADDR:
				begin
					if (wr_tog)
						vram_addr[7:0] <= bus.cpu_dat;
					else
						vram_addr[13:8] <= bus.cpu_dat[5:0];
					wr_tog <= !wr_tog;
				end
				default: ;
			endcase
		end

		// ctrl bit 2 picks across or down
		if (ppu_ce && ppu_idx == nes_bus_pkg::PPU_DATA)
		begin
			vram_addr <= vram_addr + (ppu_ctrl[2] ? 14'd32 : 14'd1);
		end
	end

	// apu regs in the lower half, palette in the upper
	assign mem_wa = apu_ce ? {1'b0, bus.cpu_addr[4:0]} : {1'b1, vram_addr[4:0]};
	assign mem_we = apu_we || pal_we;

	// backdrop entries share one cell
	assign mem_wa_pm = (mem_wa[5] && mem_wa[3:0] == 4'd0) ? 6'h20 : mem_wa;
	assign mem_ra_pm = (rd_addr[5] && rd_addr[3:0] == 4'd0) ? 6'h20 : rd_addr[5:0];

	ram_dp #(
		.ADDR_W(6)
	) regs_mem (
		.m2(m2),
		.we(mem_we),
		.wr_addr(mem_wa_pm),
		.din(bus.cpu_dat),
		.rd_addr(mem_ra_pm),
		.dout(mem_do)
	);

	ram_dp #(
		.ADDR_W(8)
	) oam_mem (
		.m2(m2),
		.we(oam_we),
		.wr_addr(oam_addr),
		.din(bus.cpu_dat),
		.rd_addr(rd_addr[7:0]),
		.dout(oam_do)
	);

	always_comb
	begin
		case (rd_addr[5:0])
			6'd0: regs_byte = ppu_ctrl;
			6'd1: regs_byte = ppu_mask;
			6'd2: regs_byte = ppu_scrl[15:8];
			6'd3: regs_byte = ppu_scrl[7:0];
			6'd15: regs_byte = `SS_MAGIC;
			6'd63: regs_byte = {5'd0, ss_src};
			default: regs_byte = 8'hff;
		endcase
	end

	// select registered alongside the ram read
	always_ff @(posedge m2)
	begin
		regs_q <= regs_byte;
		sel_oam_q <= rd_addr[8];
		sel_mem_q <= rd_addr[7:6] == 2'b10;
	end

	assign dout = sel_oam_q ? oam_do : (sel_mem_q ? mem_do : regs_q);

endmodule

`default_nettype wire

/* design/ss_sw.sv */
`default_nettype none

`include "sst_settings.svh"

module ss_sw
(
	input logic m2,
	input logic map_rst,
	input nes_bus_pkg::cpu_bus_t bus,
	input sst_pkg::sys_cfg_t sys_cfg,
	input logic data_hit,
	output logic ss_act,
	output logic ss_we,
	output logic sniff_off,
	output sst_pkg::ss_src_t ss_src
);

	logic [7:0] joy1;
	logic joy_hit_save;
	logic joy_hit_load;
	logic btn_hit;
	logic hit;
	logic hit_q;
	logic ss_req;
	logic ss_ack;
	logic nmi;
	logic game_out;
	logic game_ret;

	joy_rdr joy_inst (
		.m2(m2),
		.map_rst(map_rst),
		.bus(bus),
		.joy(joy1)
	);

	assign joy_hit_save = joy1 == sys_cfg.key_save && sys_cfg.key_save != `KEY_OFF;
	assign joy_hit_load = joy1 == sys_cfg.key_load && sys_cfg.key_load != `KEY_OFF;
	// the button is shared with the fds disk swap
	assign btn_hit = sys_cfg.ss_btn && !sys_cfg.fds_sw;
	assign hit = sys_cfg.ss_on && (joy_hit_save || joy_hit_load || btn_hit);

	assign nmi = bus.cpu_rw && bus.cpu_addr == nes_bus_pkg::NMI_VEC_LO;
	assign game_out = nmi && ss_req && !ss_ack;
	assign game_ret = nmi && ss_ack;

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			hit_q <= 1'b0;
			ss_req <= 1'b0;
			ss_act <= 1'b0;
			ss_ack <= 1'b0;
		end
		else
		begin
			hit_q <= hit;

			// no new request while the handler runs
			if (ss_act)
				ss_req <= 1'b0;
			else if (hit && !hit_q)
				ss_req <= 1'b1;

			if (game_out)
				ss_act <= 1'b1;
			else if (game_ret)
				ss_act <= 1'b0;

			if (game_ret || !ss_act)
				ss_ack <= 1'b0;
			else if (data_hit && !bus.cpu_rw)
				ss_ack <= 1'b1;
		end
	end

	always_ff @(posedge m2)
	begin
		if (hit && !hit_q && !ss_act)
		begin
			ss_src <= '{btn: btn_hit, load: joy_hit_load, save: joy_hit_save};
		end
	end

	assign ss_we = data_hit && !bus.cpu_rw && ss_act;

	// handler writes before ack must not reach the shadow copies
	assign sniff_off = ss_act && !ss_ack;

endmodule

`default_nettype wire

/* design/sst_controller.sv */
`default_nettype none

`include "sst_settings.svh"

module sst_controller
(
	input logic m2,
	input logic map_rst,
	input nes_bus_pkg::cpu_bus_t bus,
	input sst_pkg::sys_cfg_t sys_cfg,
	input logic [7:0] ss_di,
	output logic [7:0] ss_do,
	output logic ss_oe_cpu,
	output sst_pkg::ss_ctrl_t ss_ctrl,
	input logic pi_req,
	input logic [`SS_AW-1:0] pi_addr,
	output logic pi_ack,
	output logic [7:0] pi_dat
);

	logic addr_hit;
	logic data_hit;
	logic [`SS_AW-1:0] cpu_ss_addr;
	logic [`SS_AW-1:0] ss_addr;
	logic snif_ce;
	logic [7:0] snif_do;
	logic ss_act;
	logic ss_we;
	logic sniff_off;
	sst_pkg::ss_src_t ss_src;
	logic req_q;

	assign addr_hit = bus.cpu_addr == `SST_ADDR_REG;
	assign data_hit = bus.cpu_addr == `SST_DATA_REG;

	// address written high byte first, low bits shift up
	always_ff @(posedge m2)
	begin
		if (map_rst)
			cpu_ss_addr <= '0;
		else if (addr_hit && !bus.cpu_rw)
			cpu_ss_addr <= {cpu_ss_addr[`SS_AW-9:0], bus.cpu_dat};
		else if (data_hit)
			cpu_ss_addr <= cpu_ss_addr + 1'b1;
	end

	assign ss_addr = pi_req ? pi_addr : cpu_ss_addr;

	// 0x080 to 0x1ff comes from the sniffer
	assign snif_ce = ss_addr[`SS_AW-1:`SNIF_AW] == '0 && ss_addr[`SNIF_AW-1:7] != '0;
	assign ss_do = snif_ce ? snif_do : ss_di;
	assign ss_oe_cpu = data_hit && bus.cpu_rw;

	assign ss_ctrl.act = ss_act;
	assign ss_ctrl.we = ss_we;
	assign ss_ctrl.addr = ss_addr;

	// host read, one cycle for the ram, one to capture
	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			req_q <= 1'b0;
			pi_ack <= 1'b0;
		end
		else
		begin
			req_q <= pi_req;
			pi_ack <= pi_req && req_q;
		end
	end

	always_ff @(posedge m2)
	begin
		if (pi_req && req_q && !pi_ack)
		begin
			pi_dat <= ss_do;
		end
	end

	ss_sw ss_sw_inst (
		.m2(m2),
		.map_rst(map_rst),
		.bus(bus),
		.sys_cfg(sys_cfg),
		.data_hit(data_hit),
		.ss_act(ss_act),
		.ss_we(ss_we),
		.sniff_off(sniff_off),
		.ss_src(ss_src)
	);

	sniffer snif_inst (
		.m2(m2),
		.bus(bus),
		.sniff_off(sniff_off),
		.ss_src(ss_src),
		.rd_addr(ss_addr[`SNIF_AW-1:0]),
		.dout(snif_do)
	);

endmodule

`default_nettype wire

/* bench/sst_tb.sv */
`default_nettype none

`include "sst_settings.svh"

module sst_tb;

	// the tests take roughly 800 cycles
	localparam int MAX_CYCLES = 4000;
	localparam int ACK_WAIT = 16;

	logic m2;
	logic map_rst;
	nes_bus_pkg::cpu_bus_t bus;
	sst_pkg::sys_cfg_t sys_cfg;
	logic [7:0] ss_di;
	logic [7:0] ss_do;
	logic ss_oe_cpu;
	sst_pkg::ss_ctrl_t ss_ctrl;
	logic pi_req;
	logic [`SS_AW-1:0] pi_addr;
	logic pi_ack;
	logic [7:0] pi_dat;

	logic [31:0] lfsr;
	int cycles;
	int checks;
	int errors;
	// last value written to $2000 that should have landed
	logic [7:0] ctrl_exp;

	sst_controller dut_i (
		.m2(m2),
		.map_rst(map_rst),
		.bus(bus),
		.sys_cfg(sys_cfg),
		.ss_di(ss_di),
		.ss_do(ss_do),
		.ss_oe_cpu(ss_oe_cpu),
		.ss_ctrl(ss_ctrl),
		.pi_req(pi_req),
		.pi_addr(pi_addr),
		.pi_ack(pi_ack),
		.pi_dat(pi_dat)
	);

	always #20 m2 = ~m2;

	always @(posedge m2)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("run stopped after %0d cycles, tests did not finish", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// one bus cycle that returns at the negedge inside it
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] dat, input logic rw);
		@(posedge m2);
		bus <= '{cpu_addr: addr, cpu_dat: dat, cpu_rw: rw};
		@(negedge m2);
	endtask

	task automatic bus_idle(input int n);
		repeat (n) bus_cycle(16'h0000, 8'h00, 1'b1);
	endtask

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		@(negedge m2);
		while (pi_ack !== level && n < ACK_WAIT)
		begin
			@(negedge m2);
			n++;
		end
		if (pi_ack !== level)
		begin
			$display("host handshake stuck: pi_ack did not go %0b %s", level, what);
			errors++;
		end
	endtask

	task automatic host_check(input logic [`SS_AW-1:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		@(posedge m2);
		bus <= '{cpu_addr: 16'h0000, cpu_dat: 8'h00, cpu_rw: 1'b1};
		pi_req <= 1'b1;
		pi_addr <= addr;
		wait_ack(1'b1, "after pi_req rose");
		got = pi_dat;
		@(posedge m2);
		pi_req <= 1'b0;
		wait_ack(1'b0, "after pi_req fell");
		check_val($sformatf("pi_dat[%h]", addr), got, exp);
	endtask

	task automatic test_done(input string name, input int err0);
		$display("test %s finished with %0d errors", name, errors - err0);
	endtask

	task automatic test_ppu_shadow();
		int err0;
		logic [7:0] c;
		logic [7:0] m;
		logic [7:0] junk;
		logic [7:0] s1;
		logic [7:0] s2;
		err0 = errors;
		rand_byte(c);
		rand_byte(m);
		rand_byte(junk);
		rand_byte(s1);
		rand_byte(s2);
		bus_cycle(16'h2002, 8'h00, 1'b1);
		bus_cycle(16'h2000, c, 1'b0);
		bus_cycle(16'h2001, m, 1'b0);
		bus_cycle(16'h2005, junk, 1'b0);
		// status read restarts the write toggle
		bus_cycle(16'h2002, 8'h00, 1'b1);
		bus_cycle(16'h2005, s1, 1'b0);
		bus_cycle(16'h2005, s2, 1'b0);
		bus_idle(1);
		ctrl_exp = c;
		host_check(11'h0c0, c);
		host_check(11'h0c1, m);
		host_check(11'h0c2, s1);
		host_check(11'h0c3, s2);
		host_check(11'h0cf, 8'h53);
		host_check(11'h0c5, 8'hff);
		test_done("ppu shadow", err0);
	endtask

	task automatic test_apu_palette();
		int err0;
		logic [7:0] apu [32];
		logic [7:0] pal [32];
		err0 = errors;
		for (int i = 0; i < 32; i++)
		begin
			rand_byte(apu[i]);
			bus_cycle(16'h4000 | 16'(i), apu[i], 1'b0);
		end
		// increment by one, then point at $3f00
		bus_cycle(16'h2000, 8'h00, 1'b0);
		ctrl_exp = 8'h00;
		bus_cycle(16'h2002, 8'h00, 1'b1);
		bus_cycle(16'h2006, 8'h3f, 1'b0);
		bus_cycle(16'h2006, 8'h00, 1'b0);
		for (int i = 0; i < 32; i++)
		begin
			rand_byte(pal[i]);
			bus_cycle(16'h2007, pal[i], 1'b0);
		end
		bus_idle(1);
		for (int i = 0; i < 32; i++)
			host_check(11'h080 | 11'(i), apu[i]);
		// $3f10 was written after $3f00 and shares its cell
		for (int i = 0; i < 32; i++)
			host_check(11'h0a0 | 11'(i), (i % 16 == 0) ? pal[16] : pal[i]);
		test_done("apu and palette", err0);
	endtask

	task automatic test_oam();
		int err0;
		logic [7:0] start;
		logic [7:0] idx;
		logic [7:0] oam [24];
		err0 = errors;
		start = 8'hf4;
		bus_cycle(16'h2003, start, 1'b0);
		for (int i = 0; i < 24; i++)
		begin
			rand_byte(oam[i]);
			bus_cycle(16'h2004, oam[i], 1'b0);
		end
		bus_idle(1);
		for (int i = 0; i < 24; i++)
		begin
			idx = start + 8'(i);
			host_check({3'b001, idx}, oam[i]);
		end
		test_done("oam", err0);
	endtask

	task automatic test_cpu_port();
		int err0;
		logic [7:0] d;
		err0 = errors;
		bus_cycle(`SST_ADDR_REG, 8'h03, 1'b0);
		bus_cycle(`SST_ADDR_REG, 8'h40, 1'b0);
		bus_idle(1);
		check_val("ss_ctrl.addr", ss_ctrl.addr, 16'h0340);
		bus_cycle(`SST_DATA_REG, 8'h5a, 1'b0);
		check_val("ss_ctrl.we", ss_ctrl.we, 16'h0000);
		check_val("ss_oe_cpu", ss_oe_cpu, 16'h0000);
		bus_idle(1);
		check_val("ss_ctrl.addr", ss_ctrl.addr, 16'h0341);
		rand_byte(d);
		@(posedge m2);
		ss_di <= d;
		bus_cycle(`SST_DATA_REG, 8'h00, 1'b1);
		check_val("ss_do", ss_do, d);
		check_val("ss_oe_cpu", ss_oe_cpu, 16'h0001);
		bus_idle(1);
		check_val("ss_ctrl.addr", ss_ctrl.addr, 16'h0342);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0000);
		test_done("cpu register port", err0);
	endtask

	task automatic test_save_cycle();
		int err0;
		logic [7:0] key;
		err0 = errors;
		rand_byte(key);
		if (key == 8'h00 || key == 8'hff)
			key = 8'h41;
		@(posedge m2);
		sys_cfg <= '{ss_on: 1'b1, ss_btn: 1'b0, fds_sw: 1'b0, key_save: key, key_load: 8'hff};
		// strobe, then eight button reads with the first one as the msb
		bus_cycle(nes_bus_pkg::JOY_PORT, 8'h01, 1'b0);
		bus_cycle(nes_bus_pkg::JOY_PORT, 8'h00, 1'b0);
		for (int i = 7; i >= 0; i--)
			bus_cycle(nes_bus_pkg::JOY_PORT, {7'd0, key[i]}, 1'b1);
		bus_idle(3);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0000);
		bus_cycle(nes_bus_pkg::NMI_VEC_LO, 8'h00, 1'b1);
		bus_idle(1);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0001);
		bus_cycle(16'h2000, ~ctrl_exp, 1'b0);
		bus_cycle(`SST_DATA_REG, 8'h00, 1'b0);
		check_val("ss_ctrl.we", ss_ctrl.we, 16'h0001);
		bus_idle(1);
		check_val("ss_ctrl.we", ss_ctrl.we, 16'h0000);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0001);
		bus_cycle(nes_bus_pkg::NMI_VEC_LO, 8'h00, 1'b1);
		bus_idle(1);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0000);
		host_check(11'h0c0, ctrl_exp);
		host_check(11'h0ff, 8'h01);
		test_done("save-state cycle", err0);
	endtask

	task automatic test_reset();
		int err0;
		err0 = errors;
		// new hit edge arms a request
		@(posedge m2);
		sys_cfg.ss_on <= 1'b0;
		bus_idle(2);
		@(posedge m2);
		sys_cfg.ss_on <= 1'b1;
		bus_idle(2);
		@(posedge m2);
		pi_req <= 1'b1;
		pi_addr <= 11'h0c0;
		wait_ack(1'b1, "before reset");
		@(posedge m2);
		map_rst <= 1'b1;
		bus_idle(2);
		check_val("pi_ack", pi_ack, 16'h0000);
		@(posedge m2);
		pi_req <= 1'b0;
		map_rst <= 1'b0;
		bus_idle(2);
		bus_cycle(nes_bus_pkg::NMI_VEC_LO, 8'h00, 1'b1);
		bus_idle(1);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0000);
		// a button press arms a fresh request
		@(posedge m2);
		sys_cfg.ss_btn <= 1'b1;
		bus_idle(2);
		bus_cycle(nes_bus_pkg::NMI_VEC_LO, 8'h00, 1'b1);
		bus_idle(1);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0001);
		// reset while the handler runs
		@(posedge m2);
		map_rst <= 1'b1;
		sys_cfg.ss_btn <= 1'b0;
		bus_idle(2);
		check_val("ss_ctrl.act", ss_ctrl.act, 16'h0000);
		@(posedge m2);
		map_rst <= 1'b0;
		bus_idle(1);
		test_done("reset", err0);
	endtask

	initial
	begin
		m2 = 1'b0;
		map_rst = 1'b1;
		bus = '{cpu_addr: 16'h0000, cpu_dat: 8'h00, cpu_rw: 1'b1};
		sys_cfg = '{ss_on: 1'b0, ss_btn: 1'b0, fds_sw: 1'b0, key_save: 8'hff, key_load: 8'hff};
		ss_di = 8'h00;
		pi_req = 1'b0;
		pi_addr = '0;
		lfsr = 32'h3bf2;
		cycles = 0;
		checks = 0;
		errors = 0;
		ctrl_exp = 8'h00;
		repeat (16) @(posedge m2);
		map_rst <= 1'b0;
		test_ppu_shadow();
		test_apu_palette();
		test_oam();
		test_cpu_port();
		test_save_cycle();
		test_reset();
		$display("checks run: %0d, checks failed: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sst_ctrl.f */
+incdir+design
design/nes_bus_pkg.sv
design/sst_pkg.sv
design/ram_dp.sv
design/joy_rdr.sv
design/sniffer.sv
design/ss_sw.sv
design/sst_controller.sv
bench/sst_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sst_ctrl.f --top-module sst_tb -o sst_tb_sim
./obj_dir/sst_tb_sim | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
